// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cpu_datapath_tb
FILELIST ?= cpu_datapath.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q '^sim passed$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cpu_datapath.f ====
design/lc3b_pkg.sv
design/fetch_unit.sv
design/issue_control.sv
design/reorder_buffer.sv
design/regfile.sv
design/alu_rs_unit.sv
design/cpu_datapath.sv
dv/cpu_datapath_assert.sv
dv/cpu_datapath_tb.sv

// ==== design/alu_rs_unit.sv ====
`timescale 1ns/10ps

module alu_rs_unit
(
	input logic clk,
	input logic rst_n,
	input logic rs_we,
	input lc3b_pkg::alu_op_e rs_op,
	input logic [lc3b_pkg::word_w-1:0] rs_vj,
	input logic [lc3b_pkg::word_w-1:0] rs_vk,
	input logic [lc3b_pkg::rob_addr_w-1:0] rs_qj,
	input logic [lc3b_pkg::rob_addr_w-1:0] rs_qk,
	input logic rs_rj,
	input logic rs_rk,
	input logic [lc3b_pkg::rob_addr_w-1:0] rs_dest_tag,
	output logic rs_full,
	output logic cdb_valid,
	output logic [lc3b_pkg::rob_addr_w-1:0] cdb_tag,
	output logic [lc3b_pkg::word_w-1:0] cdb_value
);

	lc3b_pkg::alu_op_e op_q [lc3b_pkg::num_alu_rs];
	logic [lc3b_pkg::word_w-1:0] vj_q [lc3b_pkg::num_alu_rs];
	logic [lc3b_pkg::word_w-1:0] vk_q [lc3b_pkg::num_alu_rs];
	logic [lc3b_pkg::rob_addr_w-1:0] qj_q [lc3b_pkg::num_alu_rs];
	logic [lc3b_pkg::rob_addr_w-1:0] qk_q [lc3b_pkg::num_alu_rs];
	logic [lc3b_pkg::rob_addr_w-1:0] dest_q [lc3b_pkg::num_alu_rs];
	logic [lc3b_pkg::num_alu_rs-1:0] busy, rj, rk;
	logic [lc3b_pkg::num_alu_rs-1:0] snoop_j, snoop_k, ready;
	logic [$clog2(lc3b_pkg::num_alu_rs)-1:0] wr_idx, sel_idx;
	logic sel_valid;
	logic [lc3b_pkg::word_w-1:0] alu_result;

	assign rs_full = &busy;
	assign ready = busy & rj & rk;
	assign sel_valid = |ready;

	always_comb
	begin
		wr_idx = '0;
		sel_idx = '0;
		// Walk downward so the lowest index is left standing
		for (int i = lc3b_pkg::num_alu_rs - 1; i >= 0; i--)
		begin
			if (!busy[i])
				wr_idx = ($clog2(lc3b_pkg::num_alu_rs))'(i);
			if (ready[i])
				sel_idx = ($clog2(lc3b_pkg::num_alu_rs))'(i);
		end
		for (int i = 0; i < lc3b_pkg::num_alu_rs; i++)
		begin
			snoop_j[i] = busy[i] && !rj[i] && cdb_valid && (qj_q[i] == cdb_tag);
			snoop_k[i] = busy[i] && !rk[i] && cdb_valid && (qk_q[i] == cdb_tag);
		end
		case (op_q[sel_idx])
			lc3b_pkg::alu_add: alu_result = vj_q[sel_idx] + vk_q[sel_idx];
			lc3b_pkg::alu_and: alu_result = vj_q[sel_idx] & vk_q[sel_idx];
			// NOT, vk holds all ones
			default: alu_result = vj_q[sel_idx] ^ vk_q[sel_idx];
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			busy <= '0;
			rj <= '0;
			rk <= '0;
			cdb_valid <= 1'b0;
		end
		else
		begin
			cdb_valid <= sel_valid;
			rj <= rj | snoop_j;
			rk <= rk | snoop_k;
			if (sel_valid)
				busy[sel_idx] <= 1'b0;
			if (rs_we)
			begin
				busy[wr_idx] <= 1'b1;
				rj[wr_idx] <= rs_rj;
				rk[wr_idx] <= rs_rk;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < lc3b_pkg::num_alu_rs; i++)
		begin
			if (snoop_j[i])
				vj_q[i] <= cdb_value;
			if (snoop_k[i])
				vk_q[i] <= cdb_value;
		end
		if (rs_we)
		begin
			op_q[wr_idx] <= rs_op;
			vj_q[wr_idx] <= rs_vj;
			vk_q[wr_idx] <= rs_vk;
			qj_q[wr_idx] <= rs_qj;
			qk_q[wr_idx] <= rs_qk;
			dest_q[wr_idx] <= rs_dest_tag;
		end
		if (sel_valid)
		begin
			cdb_tag <= dest_q[sel_idx];
			cdb_value <= alu_result;
		end
	end

endmodule

// ==== design/cpu_datapath.sv ====
`timescale 1ns/10ps

module cpu_datapath
(
	input logic clk,
	input logic rst_n,
	input logic [lc3b_pkg::word_w-1:0] imem_rdata,
	input logic imem_resp,
	output logic imem_read,
	output logic [lc3b_pkg::word_w-1:0] imem_address,
	output logic commit_valid,
	output logic [lc3b_pkg::reg_w-1:0] commit_dest,
	output logic [lc3b_pkg::word_w-1:0] commit_value
);

	// Fetch and issue
	lc3b_pkg::lc3b_instr instr;
	logic instr_valid, stall;

	// Register file lookups
	logic [lc3b_pkg::reg_w-1:0] sr1, sr2, dr;
	logic [lc3b_pkg::word_w-1:0] sr1_value, sr2_value;
	logic sr1_busy, sr2_busy, rename_we;
	logic [lc3b_pkg::rob_addr_w-1:0] sr1_tag, sr2_tag, rename_tag;

	// Reorder buffer
	logic rob_we, rob_full, src1_ready, src2_ready;
	logic [lc3b_pkg::reg_w-1:0] rob_dest;
	logic [lc3b_pkg::rob_addr_w-1:0] rob_src1_tag, rob_src2_tag, rob_tail, commit_tag;
	logic [lc3b_pkg::word_w-1:0] src1_value, src2_value;

	// Stations and CDB
	logic rs_we, rs_rj, rs_rk, rs_full, cdb_valid;
	lc3b_pkg::alu_op_e rs_op;
	logic [lc3b_pkg::word_w-1:0] rs_vj, rs_vk, cdb_value;
	logic [lc3b_pkg::rob_addr_w-1:0] rs_qj, rs_qk, rs_dest_tag, cdb_tag;

	fetch_unit fetch_unit_i (.clk, .rst_n, .stall, .imem_rdata, .imem_resp, .imem_read,
		.imem_address, .instr, .instr_valid);

	issue_control issue_control_i (.clk, .rst_n, .instr, .instr_valid, .stall,
		.sr1, .sr2, .dr, .sr1_value, .sr1_busy, .sr1_tag, .sr2_value, .sr2_busy, .sr2_tag,
		.rename_we, .rename_tag, .rob_we, .rob_dest, .rob_src1_tag, .rob_src2_tag,
		.rob_tail, .rob_full, .src1_ready, .src1_value, .src2_ready, .src2_value,
		.rs_we, .rs_op, .rs_vj, .rs_vk, .rs_qj, .rs_qk, .rs_rj, .rs_rk, .rs_dest_tag,
		.rs_full);

	reorder_buffer reorder_buffer_i (.clk, .rst_n, .rob_we, .rob_dest, .rob_src1_tag,
		.rob_src2_tag, .rob_tail, .rob_full, .src1_ready, .src1_value, .src2_ready,
		.src2_value, .cdb_valid, .cdb_tag, .cdb_value, .commit_valid, .commit_dest,
		.commit_value, .commit_tag);

	regfile regfile_i (.clk, .rst_n, .sr1, .sr2, .dr, .rename_we, .rename_tag,
		.commit_valid, .commit_dest, .commit_value, .commit_tag, .sr1_value, .sr1_busy,
		.sr1_tag, .sr2_value, .sr2_busy, .sr2_tag);

	alu_rs_unit alu_rs_unit_i (.clk, .rst_n, .rs_we, .rs_op, .rs_vj, .rs_vk, .rs_qj,
		.rs_qk, .rs_rj, .rs_rk, .rs_dest_tag, .rs_full, .cdb_valid, .cdb_tag, .cdb_value);

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit
(
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic [lc3b_pkg::word_w-1:0] imem_rdata,
	input logic imem_resp,
	output logic imem_read,
	output logic [lc3b_pkg::word_w-1:0] imem_address,
	output lc3b_pkg::lc3b_instr instr,
	output logic instr_valid
);

	logic [lc3b_pkg::word_w-1:0] pc;
	logic take;

	// Issue accepts the held word this cycle
	assign take = instr_valid && !stall;
	assign imem_address = pc;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pc <= '0;
			imem_read <= 1'b0;
			instr_valid <= 1'b0;
		end
		else if (imem_read && imem_resp)
		begin
			imem_read <= 1'b0;
			instr_valid <= 1'b1;
			pc <= pc + 16'd2;
		end
		else
		begin
			if (take)
				instr_valid <= 1'b0;
			// Only ask again once the slot is empty or being emptied
			if (!imem_read && (!instr_valid || take))
				imem_read <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (imem_read && imem_resp)
			instr <= imem_rdata;
	end

endmodule

// ==== design/issue_control.sv ====
`timescale 1ns/10ps

module issue_control
(
	input logic clk,
	input logic rst_n,
	input lc3b_pkg::lc3b_instr instr,
	input logic instr_valid,
	output logic stall,
	// Register file
	output logic [lc3b_pkg::reg_w-1:0] sr1,
	output logic [lc3b_pkg::reg_w-1:0] sr2,
	output logic [lc3b_pkg::reg_w-1:0] dr,
	input logic [lc3b_pkg::word_w-1:0] sr1_value,
	input logic sr1_busy,
	input logic [lc3b_pkg::rob_addr_w-1:0] sr1_tag,
	input logic [lc3b_pkg::word_w-1:0] sr2_value,
	input logic sr2_busy,
	input logic [lc3b_pkg::rob_addr_w-1:0] sr2_tag,
	output logic rename_we,
	output logic [lc3b_pkg::rob_addr_w-1:0] rename_tag,
	// Reorder buffer
	output logic rob_we,
	output logic [lc3b_pkg::reg_w-1:0] rob_dest,
	output logic [lc3b_pkg::rob_addr_w-1:0] rob_src1_tag,
	output logic [lc3b_pkg::rob_addr_w-1:0] rob_src2_tag,
	input logic [lc3b_pkg::rob_addr_w-1:0] rob_tail,
	input logic rob_full,
	input logic src1_ready,
	input logic [lc3b_pkg::word_w-1:0] src1_value,
	input logic src2_ready,
	input logic [lc3b_pkg::word_w-1:0] src2_value,
	// Reservation stations
	output logic rs_we,
	output lc3b_pkg::alu_op_e rs_op,
	output logic [lc3b_pkg::word_w-1:0] rs_vj,
	output logic [lc3b_pkg::word_w-1:0] rs_vk,
	output logic [lc3b_pkg::rob_addr_w-1:0] rs_qj,
	output logic [lc3b_pkg::rob_addr_w-1:0] rs_qk,
	output logic rs_rj,
	output logic rs_rk,
	output logic [lc3b_pkg::rob_addr_w-1:0] rs_dest_tag,
	input logic rs_full
);

	logic [3:0] opcode;
	logic is_alu;
	logic is_not;
	logic go;
	logic [lc3b_pkg::word_w-1:0] imm_ext;
	logic [lc3b_pkg::word_w-1:0] issued_count;

	assign opcode = instr.reg_form.opcode;
	assign is_not = (opcode == lc3b_pkg::op_not);
	assign is_alu = (opcode == lc3b_pkg::op_add) || (opcode == lc3b_pkg::op_and) || is_not;
	assign imm_ext = {{(lc3b_pkg::word_w-5){instr.imm_form.imm5[4]}}, instr.imm_form.imm5};

	// Non-ALU words pass through without stalling or allocating
	assign stall = instr_valid && is_alu && (rob_full || rs_full);
	assign go = instr_valid && is_alu && !rob_full && !rs_full;

	assign sr1 = instr.reg_form.sr1;
	assign sr2 = instr.reg_form.sr2;
	assign dr = instr.reg_form.dr;
	assign rob_we = go;
	assign rs_we = go;
	assign rename_we = go;
	assign rename_tag = rob_tail;
	assign rs_dest_tag = rob_tail;
	assign rob_dest = instr.reg_form.dr;
	assign rob_src1_tag = sr1_tag;
	assign rob_src2_tag = sr2_tag;
	assign rs_qj = sr1_tag;
	assign rs_qk = sr2_tag;

	always_comb
	begin
		case (opcode)
			lc3b_pkg::op_and: rs_op = lc3b_pkg::alu_and;
			lc3b_pkg::op_not: rs_op = lc3b_pkg::alu_not;
			default: rs_op = lc3b_pkg::alu_add;
		endcase

		// Register file first, then the ROB, else wait on the tag
		rs_vj = sr1_busy ? src1_value : sr1_value;
		rs_rj = !sr1_busy || src1_ready;

		if (is_not)
		begin
			// Complement is computed as XOR with all ones
			rs_vk = '1;
			rs_rk = 1'b1;
		end
		else if (instr.imm_form.mode)
		begin
			rs_vk = imm_ext;
			rs_rk = 1'b1;
		end
		else
		begin
			rs_vk = sr2_busy ? src2_value : sr2_value;
			rs_rk = !sr2_busy || src2_ready;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			issued_count <= '0;
		else if (go)
			issued_count <= issued_count + 1'b1;
	end

endmodule

// ==== design/lc3b_pkg.sv ====
package lc3b_pkg;

	// Datapath and storage sizes
	localparam int word_w = 16;
	localparam int num_regs = 8;
	localparam int reg_w = 3;
	localparam int rob_depth = 8;
	localparam int rob_addr_w = 3;
	localparam int num_alu_rs = 3;

	// Opcodes handled by the ALU stations
	localparam logic [3:0] op_add = 4'b0001;
	localparam logic [3:0] op_and = 4'b0101;
	localparam logic [3:0] op_not = 4'b1001;

	typedef enum logic [1:0]
	{
		alu_add,
		alu_and,
		alu_not
	} alu_op_e;

	// One instruction word, two decodings selected by bit 5
	typedef union packed
	{
		struct packed
		{
			logic [3:0] opcode;
			logic [reg_w-1:0] dr;
			logic [reg_w-1:0] sr1;
			logic mode;
			logic [1:0] pad;
			logic [reg_w-1:0] sr2;
		} reg_form;
		struct packed
		{
			logic [3:0] opcode;
			logic [reg_w-1:0] dr;
			logic [reg_w-1:0] sr1;
			logic mode;
			logic [4:0] imm5;
		} imm_form;
	} lc3b_instr;

endpackage

// ==== design/regfile.sv ====
`timescale 1ns/10ps

module regfile
(
	input logic clk,
	input logic rst_n,
	input logic [lc3b_pkg::reg_w-1:0] sr1,
	input logic [lc3b_pkg::reg_w-1:0] sr2,
	input logic [lc3b_pkg::reg_w-1:0] dr,
	input logic rename_we,
	input logic [lc3b_pkg::rob_addr_w-1:0] rename_tag,
	input logic commit_valid,
	input logic [lc3b_pkg::reg_w-1:0] commit_dest,
	input logic [lc3b_pkg::word_w-1:0] commit_value,
	input logic [lc3b_pkg::rob_addr_w-1:0] commit_tag,
	output logic [lc3b_pkg::word_w-1:0] sr1_value,
	output logic sr1_busy,
	output logic [lc3b_pkg::rob_addr_w-1:0] sr1_tag,
	output logic [lc3b_pkg::word_w-1:0] sr2_value,
	output logic sr2_busy,
	output logic [lc3b_pkg::rob_addr_w-1:0] sr2_tag
);

	logic [lc3b_pkg::word_w-1:0] value_q [lc3b_pkg::num_regs];
	logic [lc3b_pkg::rob_addr_w-1:0] tag_q [lc3b_pkg::num_regs];
	logic [lc3b_pkg::num_regs-1:0] busy_q;
	logic commit_hit;

	// Older results whose register was renamed again are dropped
	assign commit_hit = commit_valid && busy_q[commit_dest]
		&& (tag_q[commit_dest] == commit_tag);

	assign sr1_value = value_q[sr1];
	assign sr1_busy = busy_q[sr1];
	assign sr1_tag = tag_q[sr1];
	assign sr2_value = value_q[sr2];
	assign sr2_busy = busy_q[sr2];
	assign sr2_tag = tag_q[sr2];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < lc3b_pkg::num_regs; i++)
				value_q[i] <= '0;
			busy_q <= '0;
		end
		else
		begin
			if (commit_hit)
			begin
				value_q[commit_dest] <= commit_value;
				busy_q[commit_dest] <= 1'b0;
			end
			// New rename wins over a retire to the same register
			if (rename_we)
				busy_q[dr] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rename_we)
			tag_q[dr] <= rename_tag;
	end

endmodule

// ==== design/reorder_buffer.sv ====
`timescale 1ns/10ps

module reorder_buffer
(
	input logic clk,
	input logic rst_n,
	input logic rob_we,
	input logic [lc3b_pkg::reg_w-1:0] rob_dest,
	input logic [lc3b_pkg::rob_addr_w-1:0] rob_src1_tag,
	input logic [lc3b_pkg::rob_addr_w-1:0] rob_src2_tag,
	output logic [lc3b_pkg::rob_addr_w-1:0] rob_tail,
	output logic rob_full,
	output logic src1_ready,
	output logic [lc3b_pkg::word_w-1:0] src1_value,
	output logic src2_ready,
	output logic [lc3b_pkg::word_w-1:0] src2_value,
	input logic cdb_valid,
	input logic [lc3b_pkg::rob_addr_w-1:0] cdb_tag,
	input logic [lc3b_pkg::word_w-1:0] cdb_value,
	output logic commit_valid,
	output logic [lc3b_pkg::reg_w-1:0] commit_dest,
	output logic [lc3b_pkg::word_w-1:0] commit_value,
	output logic [lc3b_pkg::rob_addr_w-1:0] commit_tag
);

	logic [lc3b_pkg::rob_addr_w-1:0] head;
	logic [lc3b_pkg::rob_addr_w-1:0] tail;
	logic [lc3b_pkg::rob_addr_w:0] count;
	logic [lc3b_pkg::rob_depth-1:0] done;
	logic [lc3b_pkg::reg_w-1:0] dest_q [lc3b_pkg::rob_depth];
	logic [lc3b_pkg::word_w-1:0] value_q [lc3b_pkg::rob_depth];
	logic retire;

	assign rob_tail = tail;
	assign rob_full = (count == (lc3b_pkg::rob_addr_w+1)'(lc3b_pkg::rob_depth));
	assign retire = (count != '0) && done[head];

	// Retired entries keep their value until reallocated, so a
	// register still marked busy can read it here
	assign src1_ready = done[rob_src1_tag] || (cdb_valid && (cdb_tag == rob_src1_tag));
	assign src1_value = done[rob_src1_tag] ? value_q[rob_src1_tag] : cdb_value;
	assign src2_ready = done[rob_src2_tag] || (cdb_valid && (cdb_tag == rob_src2_tag));
	assign src2_value = done[rob_src2_tag] ? value_q[rob_src2_tag] : cdb_value;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
			done <= '0;
			commit_valid <= 1'b0;
		end
		else
		begin
			commit_valid <= retire;
			if (rob_we)
			begin
				done[tail] <= 1'b0;
				tail <= tail + 1'b1;
			end
			if (cdb_valid)
				done[cdb_tag] <= 1'b1;
			if (retire)
				head <= head + 1'b1;
			count <= count + {{lc3b_pkg::rob_addr_w{1'b0}}, rob_we}
				- {{lc3b_pkg::rob_addr_w{1'b0}}, retire};
		end
	end

	always_ff @(posedge clk)
	begin
		if (rob_we)
			dest_q[tail] <= rob_dest;
		if (cdb_valid)
			value_q[cdb_tag] <= cdb_value;
		if (retire)
		begin
			commit_dest <= dest_q[head];
			commit_value <= value_q[head];
			commit_tag <= head;
		end
	end

endmodule

// ==== dv/cpu_datapath_assert.sv ====
`timescale 1ns/10ps

module cpu_datapath_assert
(
	input logic clk,
	input logic rst_n,
	input logic imem_read,
	input logic imem_resp,
	input logic [lc3b_pkg::word_w-1:0] imem_address,
	input logic [lc3b_pkg::num_alu_rs-1:0] rs_busy,
	input logic cdb_valid,
	input logic [lc3b_pkg::word_w-1:0] issued_count,
	input logic commit_valid
);

	int failures;
	logic [lc3b_pkg::word_w-1:0] commit_count;

	// Retirements seen so far
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			commit_count <= '0;
		else if (commit_valid)
			commit_count <= commit_count + 1'b1;
	end

	// A broadcast releases the station it came from
	cdb_after_select: assert property (@(posedge clk) disable iff (!rst_n)
		cdb_valid |-> (($past(rs_busy) & ~rs_busy) != '0))
		else
		begin
			failures++;
			$error("CDB broadcast without a selected station");
		end

	// Each retirement belongs to an instruction issued earlier
	commit_from_rob: assert property (@(posedge clk) disable iff (!rst_n)
		commit_valid |-> (commit_count < issued_count))
		else
		begin
			failures++;
			$error("Commit while the ROB was empty");
		end

	// Request level and address stay put until the response
	read_held: assert property (@(posedge clk) disable iff (!rst_n)
		(imem_read && !imem_resp) |=> (imem_read && $stable(imem_address)))
		else
		begin
			failures++;
			$error("Instruction read dropped or moved before its response");
		end

endmodule

bind cpu_datapath cpu_datapath_assert cpu_datapath_assert_i (.clk(clk), .rst_n(rst_n),
	.imem_read(imem_read), .imem_resp(imem_resp), .imem_address(imem_address),
	.rs_busy(alu_rs_unit_i.busy), .cdb_valid(cdb_valid),
	.issued_count(issue_control_i.issued_count), .commit_valid(commit_valid));

// ==== dv/cpu_datapath_tb.sv ====
`timescale 1ns/10ps

module cpu_datapath_tb;

	localparam int prog_len = 200;
	localparam int timeout_cycles = prog_len * 20 + 200;

	logic clk = 1'b0;
	logic rst_n;
	logic [lc3b_pkg::word_w-1:0] imem_rdata;
	logic imem_resp;
	logic imem_read;
	logic [lc3b_pkg::word_w-1:0] imem_address;
	logic commit_valid;
	logic [lc3b_pkg::reg_w-1:0] commit_dest;
	logic [lc3b_pkg::word_w-1:0] commit_value;

	integer seed;
	logic [15:0] prog [prog_len];
	logic [15:0] ref_regs [8];
	int ref_idx;
	int alu_total;
	int commits;
	int errors;
	int cycles;

	cpu_datapath cpu_datapath_i (.clk, .rst_n, .imem_rdata, .imem_resp, .imem_read,
		.imem_address, .commit_valid, .commit_dest, .commit_value);

	always #4 clk = ~clk;

	function automatic bit is_alu_word(input logic [15:0] word);
		return (word[15:12] == lc3b_pkg::op_add) || (word[15:12] == lc3b_pkg::op_and)
			|| (word[15:12] == lc3b_pkg::op_not);
	endfunction

	// Past the program the memory returns the never-taken branch
	function automatic logic [15:0] fetch_word(input logic [15:0] addr);
		return (addr[15:1] < prog_len) ? prog[addr[15:1]] : 16'h0000;
	endfunction

	// In-order model, one ALU word per call, returns {dest, value}
	function logic [18:0] next_expected();
		logic [15:0] w;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		while (ref_idx < prog_len && !is_alu_word(prog[ref_idx]))
			ref_idx++;
		w = prog[ref_idx];
		a = ref_regs[w[8:6]];
		b = w[5] ? {{11{w[4]}}, w[4:0]} : ref_regs[w[2:0]];
		case (w[15:12])
			lc3b_pkg::op_add: res = a + b;
			lc3b_pkg::op_and: res = a & b;
			default: res = ~a;
		endcase
		ref_regs[w[11:9]] = res;
		ref_idx++;
		return {w[11:9], res};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			errors++;
			$display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, expected);
		end
	endtask

	task build_program();
		logic [31:0] r;
		logic [3:0] op;
		logic [2:0] dr;
		logic [2:0] sr1;
		logic [2:0] sr2;
		logic [2:0] last_dr;
		int pick;
		last_dr = 3'd0;
		for (int i = 0; i < prog_len; i++)
		begin
			r = $random(seed);
			pick = {$random(seed)} % 10;
			if (pick == 0)
			begin
				op = is_alu_word({r[15:12], 12'h000}) ? 4'h0 : r[15:12];
				prog[i] = {op, r[11:0]};
			end
			else
			begin
				pick = {$random(seed)} % 3;
				op = (pick == 0) ? lc3b_pkg::op_add : (pick == 1) ? lc3b_pkg::op_and
					: lc3b_pkg::op_not;
				dr = r[11:9];
				// Mostly chained on the previous destination
				sr1 = (r[18] || r[19]) ? last_dr : r[8:6];
				sr2 = r[20] ? last_dr : r[2:0];
				if (op == lc3b_pkg::op_not)
					prog[i] = {op, dr, sr1, 6'h3f};
				else if (r[5])
					prog[i] = {op, dr, sr1, 1'b1, r[4:0]};
				else
					prog[i] = {op, dr, sr1, 3'b000, sr2};
				last_dr = dr;
				alu_total++;
			end
		end
	endtask

	initial
	begin
		rst_n = 1'b0;
		imem_resp = 1'b0;
		imem_rdata = '0;
		seed = 32'he0a75ac5;
		for (int i = 0; i < 8; i++)
			ref_regs[i] = 16'h0000;
		build_program();
		repeat (10) @(posedge clk);
		#1 rst_n = 1'b1;
		wait (commits == alu_total);
		// Filler words keep flowing, none of them may commit
		repeat (40) @(posedge clk);
		check_value("commit_count", commits, alu_total);
		errors += cpu_datapath_i.cpu_datapath_assert_i.failures;
		$display("Run finished: %0d errors, %0d commits of %0d ALU words",
			errors, commits, alu_total);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			check_value("commit_valid", commit_valid, 0);
			check_value("imem_read", imem_read, 0);
		end
	end

	// Memory answers 1 to 3 cycles after the request rises
	initial
	begin : memory_model
		int lat;
		bit first_request;
		first_request = 1'b1;
		forever
		begin
			@(negedge clk);
			if (rst_n && imem_read)
			begin
				if (first_request)
					check_value("imem_address", imem_address, 0);
				first_request = 1'b0;
				lat = 1 + {$random(seed)} % 3;
				repeat (lat) @(posedge clk);
				#1;
				imem_resp = 1'b1;
				imem_rdata = fetch_word(imem_address);
				@(posedge clk);
				#1 imem_resp = 1'b0;
			end
		end
	end

	always @(negedge clk)
	begin : compare_commits
		logic [18:0] expected;
		if (rst_n && commit_valid)
		begin
			if (commits >= alu_total)
			begin
				errors++;
				$display("Extra commit at %0t after all ALU words retired", $time);
			end
			else
			begin
				expected = next_expected();
				check_value("commit_dest", commit_dest, expected[18:16]);
				check_value("commit_value", commit_value, expected[15:0]);
			end
			commits++;
		end
	end

	initial
	begin : watchdog
		cycles = 0;
		while (cycles < timeout_cycles)
		begin
			@(posedge clk);
			cycles++;
		end
		errors++;
		$display("Timeout after %0d cycles, the core stopped committing", cycles);
		$display("Run finished: %0d errors, %0d commits of %0d ALU words",
			errors, commits, alu_total);
		$display("sim failed");
		$finish;
	end

endmodule
